//--- Bender.yml
package:
  name: frontend

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/fast_decode.sv
      - verilog/pre_fetch_stage.sv
      - verilog/fetch_stage.sv
      - verilog/frontend_top.sv
  - target: test
    files:
      - tb/frontend_tb.sv

//--- sim.f
verilog/cpu_pkg.sv
verilog/fast_decode.sv
verilog/pre_fetch_stage.sv
verilog/fetch_stage.sv
verilog/frontend_top.sv
tb/frontend_tb.sv

//--- tb/frontend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_tb import cpu_pkg::*; ();

    logic          clk;
    logic          reset;
    redirect_t     redirect;
    mem_req_t      mem_req;
    mem_rsp_t      mem_rsp;
    logic          ds_allowin;
    logic          fs_to_valid;
    fs_to_ds_bus_t fs_to_ds_bus;

    string         test_name = "none";
    int            test_errors = 0;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            transferred = 0;
    logic [31:0]   expected_pc = reset_pc;
    logic [31:0]   floor_pc = reset_pc;
    logic [31:0]   req_line = {reset_pc[31:4], 4'b0000};
    logic          reset_last = 1'b1;
    logic          stalled_last = 1'b0;
    fs_to_ds_bus_t bus_last;

    logic          mem_busy;
    logic          accepted;
    logic [31:0]   accepted_addr;
    logic [31:0]   line_addr;
    int            wait_left;

    frontend_top dut (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .ds_allowin   (ds_allowin),
        .fs_to_valid  (fs_to_valid),
        .fs_to_ds_bus (fs_to_ds_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Memory model
    ////////////////////

    // Word 7 of every 16-word block is a beq, the rest are addiu with the
    // word index as immediate.
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        if (addr[5:2] == 4'd7) begin
            return {6'h04, 5'd1, 5'd2, 16'h0004};
        end
        return {6'h09, 5'd0, 5'd3, addr[17:2]};
    endfunction

    function automatic logic [127:0] line_at(input logic [31:0] addr);
        logic [127:0] line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = inst_at({addr[31:4], 4'b0000} + 32'(4 * k));
        end
        return line;
    endfunction

    function automatic logic is_branch(input logic [31:0] inst);
        return inst[31:26] == 6'h04;
    endfunction

    initial begin
        mem_rsp  = '0;
        mem_busy = 1'b0;
        forever begin
            @(posedge clk);
            accepted      = mem_req.req && !reset;
            accepted_addr = mem_req.addr;
            #2;
            mem_rsp = '0;
            if (reset) begin
                mem_busy = 1'b0;
            end else begin
                if (accepted) begin
                    mem_busy  = 1'b1;
                    line_addr = accepted_addr;
                    wait_left = $urandom_range(3, 0);
                end
                if (mem_busy && wait_left == 0) begin
                    mem_rsp.data_ok = 1'b1;
                    mem_rsp.data    = line_at(line_addr);
                    mem_busy        = 1'b0;
                end else if (mem_busy) begin
                    wait_left--;
                end
            end
        end
    end

    ////////////////////
    // Reporting
    ////////////////////

    task automatic value_error(input string what, input logic [159:0] expected,
                               input logic [159:0] actual);
        $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        test_errors++;
        errors++;
    endtask

    task automatic failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic finish_run();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    ////////////////////
    // Checks
    ////////////////////

    a_no_branch_second: assert property (@(posedge clk) disable iff (reset)
        (fs_to_valid && ds_allowin && fs_to_ds_bus.num == 2'd2)
            |-> !is_branch(fs_to_ds_bus.slot[1].inst))
        else value_error("branch flag of slot 1", 0, 1);

    a_branch_with_slot: assert property (@(posedge clk) disable iff (reset)
        (fs_to_valid && ds_allowin && is_branch(fs_to_ds_bus.slot[0].inst))
            |-> fs_to_ds_bus.num == 2'd2)
        else value_error("num after a branch in slot 0", 2, $sampled(fs_to_ds_bus.num));

    task automatic check_transfer();
        inst_entry_t s0;
        inst_entry_t s1;
        logic [1:0]  num;
        num = fs_to_ds_bus.num;
        s0  = fs_to_ds_bus.slot[0];
        s1  = fs_to_ds_bus.slot[1];
        assert (s0.pc >= floor_pc) else value_error("pc from before redirect", floor_pc, s0.pc);
        assert (s0.pc == expected_pc) else value_error("slot 0 pc", expected_pc, s0.pc);
        assert (s0.inst == inst_at(s0.pc)) else value_error("slot 0 inst", inst_at(s0.pc), s0.inst);
        if (num == 2'd2) begin
            assert (s1.pc == expected_pc + 32'd4)
                else value_error("slot 1 pc", expected_pc + 32'd4, s1.pc);
            assert (s1.inst == inst_at(s1.pc))
                else value_error("slot 1 inst", inst_at(s1.pc), s1.inst);
        end
        expected_pc = expected_pc + 32'(4 * num);
        transferred = transferred + num;
    endtask

    // Outputs are sampled on the falling edge, away from both the DUT edge
    // and the input drive.
    always @(negedge clk) begin
        if (reset || reset_last) begin
            assert (!mem_req.req) else value_error("mem_req.req near reset", 0, mem_req.req);
            assert (!fs_to_valid) else value_error("fs_to_valid near reset", 0, fs_to_valid);
        end
        if (reset) begin
            expected_pc  = reset_pc;
            floor_pc     = reset_pc;
            req_line     = {reset_pc[31:4], 4'b0000};
            stalled_last = 1'b0;
        end else if (redirect.valid) begin
            assert (!fs_to_valid) else value_error("fs_to_valid on redirect", 0, fs_to_valid);
            assert (!mem_req.req) else value_error("mem_req.req on redirect", 0, mem_req.req);
            expected_pc  = redirect.target;
            floor_pc     = redirect.target;
            req_line     = {redirect.target[31:4], 4'b0000};
            stalled_last = 1'b0;
        end else begin
            if (mem_req.req) begin
                assert (mem_req.addr == req_line)
                    else value_error("mem_req.addr", req_line, mem_req.addr);
                req_line = req_line + 32'd16;
            end
            assert (fs_to_valid == (fs_to_ds_bus.num != 2'd0))
                else value_error("fs_to_valid against num", fs_to_ds_bus.num != 2'd0, fs_to_valid);
            if (stalled_last) begin
                assert (fs_to_valid) else failure("fs_to_valid dropped while decode stalled");
                assert (fs_to_ds_bus == bus_last)
                    else value_error("bus during stall", bus_last, fs_to_ds_bus);
            end
            if (fs_to_valid && ds_allowin) begin
                check_transfer();
            end
            stalled_last = fs_to_valid && !ds_allowin;
            bus_last     = fs_to_ds_bus;
        end
        reset_last = reset;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic run_instructions(input int count, input logic random_stall);
        int start;
        int cycles;
        start  = transferred;
        cycles = 0;
        while (transferred - start < count) begin
            @(posedge clk);
            #2;
            ds_allowin = random_stall ? 1'($urandom_range(1, 0)) : 1'b1;
            cycles++;
            if (cycles > 30 * count + 200) begin
                failure("timed out waiting for instructions to reach decode");
                end_test();
                finish_run();
            end
        end
    endtask

    task automatic run_redirects();
        int          busy_hits;
        int          idle_hits;
        int          gap;
        logic [31:0] target;
        busy_hits = 0;
        idle_hits = 0;
        for (int k = 0; k < 16 && (busy_hits < 2 || idle_hits < 2); k++) begin
            gap = $urandom_range(6, 0);
            repeat (gap) begin
                @(posedge clk);
                #2;
                ds_allowin = 1'($urandom_range(1, 0));
            end
            @(posedge clk);
            if (mem_busy || mem_req.req) busy_hits++;
            else idle_hits++;
            #2;
            // Each target opens a fresh region above everything fetched so far.
            target          = 32'h0010_0000 * (k + 1) + (32'($urandom_range(1023, 0)) << 2);
            redirect.valid  = 1'b1;
            redirect.target = target;
            @(posedge clk);
            #2;
            redirect = '0;
            run_instructions(12, 1'b1);
        end
        if (busy_hits == 0) failure("no redirect arrived while a line was outstanding");
        if (idle_hits == 0) failure("no redirect arrived while memory was idle");
    endtask

    initial begin
        void'($urandom(32'ha4e20486));
        reset      = 1'b1;
        redirect   = '0;
        ds_allowin = 1'b0;

        begin_test("reset");
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        end_test();

        begin_test("sequential");
        run_instructions(48, 1'b0);
        end_test();

        begin_test("back_pressure");
        run_instructions(64, 1'b1);
        end_test();

        begin_test("redirect");
        run_redirects();
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Fetch restarts here after reset.
    localparam logic [31:0] reset_pc = 32'h0000_0100;

    localparam int queue_depth    = 8;
    localparam int line_words     = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    localparam int queue_cnt_bits = $clog2(queue_depth + 1);

    ////////////////////
    // Encodings
    ////////////////////

    // Primary opcodes that can change the flow of fetch. Anything else is
    // an ordinary instruction as far as the front end is concerned.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07
    } opcode_e;

    typedef enum logic [5:0] {
        funct_jr   = 6'h08,
        funct_jalr = 6'h09
    } funct_e;

    ////////////////////
    // Buses
    ////////////////////

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic         data_ok;
        logic [127:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } inst_entry_t;

    // Slots are filled from slot 0 upwards, num of them are meaningful.
    typedef struct packed {
        logic                              fill;
        logic [2:0]                        num;
        inst_entry_t [line_words-1:0]      slot;
    } pfs_to_fs_bus_t;

    // Slot 0 is the older instruction.
    typedef struct packed {
        logic [1:0]        num;
        inst_entry_t [1:0] slot;
    } fs_to_ds_bus_t;

endpackage

`default_nettype wire

//--- verilog/fast_decode.sv
`timescale 1ns/100ps
`default_nettype none

module fast_decode import cpu_pkg::*; (
    input  logic [31:0] inst,
    output logic        br_op
);

    opcode_e    opcode;
    funct_e     funct;
    logic [4:0] rt;

    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rt     = inst[20:16];

    always_comb begin
        case (opcode)
            op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz: begin
                br_op = 1'b1;
            end
            op_regimm: begin
                // bltz, bgez, bltzal and bgezal.
                br_op = (rt[3:1] == 3'b000);
            end
            op_special: begin
                br_op = (funct == funct_jr) || (funct == funct_jalr);
            end
            default: begin
                br_op = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  pfs_to_fs_bus_t pfs_to_fs_bus,
    input  logic           redirect_valid,
    input  logic           ds_allowin,
    output logic           fs_allowin,
    output logic           fs_to_valid,
    output fs_to_ds_bus_t  fs_to_ds_bus
);

    inst_entry_t queue [queue_depth];

    logic [queue_ptr_bits-1:0] start_ptr;
    logic [queue_ptr_bits-1:0] end_ptr;
    logic [queue_cnt_bits-1:0] count;

    inst_entry_t head0;
    inst_entry_t head1;
    logic        br0;
    logic        br1;

    logic [1:0] rule_num;
    logic [1:0] send_num;
    logic [1:0] xfer_num;
    logic [2:0] fill_num;
    logic       fill_take;

    logic       hold_q;
    logic [1:0] hold_num_q;

    ////////////////////
    // Queue head
    ////////////////////

    assign head0 = queue[start_ptr];
    assign head1 = queue[start_ptr + 1'b1];

    fast_decode decoder1 (
        .inst  (head0.inst),
        .br_op (br0)
    );

    fast_decode decoder2 (
        .inst  (head1.inst),
        .br_op (br1)
    );

    // A branch waits for its delay slot, and never goes out second.
    always_comb begin
        if (count == '0 || (count == 1 && br0)) begin
            rule_num = 2'd0;
        end else if (count == 1 || br1) begin
            rule_num = 2'd1;
        end else begin
            rule_num = 2'd2;
        end
    end

    // While decode stalls, the offer made on the first stalled cycle stands
    // even if a fill would now allow a larger one.
    always_comb begin
        if (redirect_valid) begin
            send_num = 2'd0;
        end else if (hold_q) begin
            send_num = hold_num_q;
        end else begin
            send_num = rule_num;
        end
    end

    assign fs_to_valid = (send_num != 2'd0);
    assign xfer_num    = (fs_to_valid && ds_allowin) ? send_num : 2'd0;

    always_comb begin
        fs_to_ds_bus         = '0;
        fs_to_ds_bus.num     = send_num;
        fs_to_ds_bus.slot[0] = head0;
        if (send_num == 2'd2) begin
            fs_to_ds_bus.slot[1] = head1;
        end
    end

    ////////////////////
    // Queue update
    ////////////////////

    assign fill_take  = pfs_to_fs_bus.fill && !redirect_valid;
    assign fill_num   = fill_take ? pfs_to_fs_bus.num : 3'd0;

    // Room for a full line must remain once this cycle's send has left.
    assign fs_allowin = (count - queue_cnt_bits'(xfer_num)) <= queue_cnt_bits'(line_words);

    always_ff @(posedge clk) begin
        if (reset || redirect_valid) begin
            start_ptr <= '0;
            end_ptr   <= '0;
            count     <= '0;
            hold_q    <= 1'b0;
        end else begin
            start_ptr <= start_ptr + queue_ptr_bits'(xfer_num);
            end_ptr   <= end_ptr + queue_ptr_bits'(fill_num);
            count     <= count - queue_cnt_bits'(xfer_num) + queue_cnt_bits'(fill_num);
            hold_q    <= fs_to_valid && !ds_allowin;
        end
    end

    always_ff @(posedge clk) begin
        hold_num_q <= send_num;
        if (fill_take) begin
            for (int i = 0; i < line_words; i++) begin
                if (i < int'(pfs_to_fs_bus.num)) begin
                    queue[end_ptr + queue_ptr_bits'(i)] <= pfs_to_fs_bus.slot[i];
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The pre-fetch stage must only have asked for a line while there was room.
    a_fill_fits: assert property (@(posedge clk) disable iff (reset)
        fill_take |-> (int'(count) - int'(xfer_num) + int'(fill_num)) <= queue_depth);

    a_num_le_count: assert property (@(posedge clk) disable iff (reset)
        fs_to_valid |-> int'(fs_to_ds_bus.num) <= int'(count));

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        int'(count) <= queue_depth);

endmodule

`default_nettype wire

//--- verilog/frontend_top.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_top import cpu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  redirect_t     redirect,
    output mem_req_t      mem_req,
    input  mem_rsp_t      mem_rsp,
    input  logic          ds_allowin,
    output logic          fs_to_valid,
    output fs_to_ds_bus_t fs_to_ds_bus
);

    logic           fs_allowin;
    logic           redirect_valid;
    pfs_to_fs_bus_t pfs_to_fs_bus;

    assign redirect_valid = redirect.valid;

    ////////////////////
    // Pre-fetch
    ////////////////////

    pre_fetch_stage u_pre_fetch_stage (
        .clk           (clk),
        .reset         (reset),
        .redirect      (redirect),
        .fs_allowin    (fs_allowin),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .pfs_to_fs_bus (pfs_to_fs_bus)
    );

    ////////////////////
    // Fetch
    ////////////////////

    fetch_stage u_fetch_stage (
        .clk            (clk),
        .reset          (reset),
        .pfs_to_fs_bus  (pfs_to_fs_bus),
        .redirect_valid (redirect_valid),
        .ds_allowin     (ds_allowin),
        .fs_allowin     (fs_allowin),
        .fs_to_valid    (fs_to_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

endmodule

`default_nettype wire

//--- verilog/pre_fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module pre_fetch_stage import cpu_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  redirect_t      redirect,
    input  logic           fs_allowin,
    output mem_req_t       mem_req,
    input  mem_rsp_t       mem_rsp,
    output pfs_to_fs_bus_t pfs_to_fs_bus
);

    logic [31:0] pc;
    logic        pfs_valid;
    logic        outstanding;
    logic        drop;
    logic [1:0]  word_off;

    logic [line_words-1:0][31:0] line_word;
    pfs_to_fs_bus_t              fill_next;

    logic                         fill_q;
    logic [2:0]                   fill_num_q;
    inst_entry_t [line_words-1:0] fill_slot_q;

    assign word_off  = pc[3:2];
    assign line_word = mem_rsp.data;

    ////////////////////
    // Memory request
    ////////////////////

    always_comb begin
        mem_req.req  = pfs_valid && !outstanding && fs_allowin && !fill_q && !redirect.valid;
        mem_req.addr = {pc[31:4], 4'b0000};
    end

    ////////////////////
    // Fill generation
    ////////////////////

    // The line is cut at the word the PC points to; the words before it
    // belong to an earlier part of the program and are not queued.
    always_comb begin
        fill_next      = '0;
        fill_next.fill = mem_rsp.data_ok && !drop && !redirect.valid;
        fill_next.num  = 3'(line_words) - {1'b0, word_off};
        for (int i = 0; i < line_words; i++) begin
            fill_next.slot[i].pc = pc + 32'(4 * i);
            if (i < line_words - int'(word_off)) begin
                fill_next.slot[i].inst = line_word[word_off + 2'(i)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pfs_valid   <= 1'b0;
            outstanding <= 1'b0;
            drop        <= 1'b0;
            pc          <= reset_pc;
            fill_q      <= 1'b0;
        end else begin
            pfs_valid <= 1'b1;
            fill_q    <= fill_next.fill;

            if (mem_req.req) begin
                outstanding <= 1'b1;
            end else if (mem_rsp.data_ok) begin
                outstanding <= 1'b0;
            end

            // A line still in flight at a redirect is thrown away on arrival.
            if (redirect.valid && outstanding && !mem_rsp.data_ok) begin
                drop <= 1'b1;
            end else if (mem_rsp.data_ok) begin
                drop <= 1'b0;
            end

            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (fill_next.fill) begin
                pc <= {pc[31:4] + 28'd1, 4'b0000};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_next.fill) begin
            fill_num_q  <= fill_next.num;
            fill_slot_q <= fill_next.slot;
        end
    end

    always_comb begin
        pfs_to_fs_bus      = '0;
        pfs_to_fs_bus.fill = fill_q;
        pfs_to_fs_bus.num  = fill_num_q;
        pfs_to_fs_bus.slot = fill_slot_q;
    end

    ////////////////////
    // Checks
    ////////////////////

    a_no_stray_data_ok: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.data_ok |-> outstanding);

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        mem_req.req |=> (!mem_req.req until mem_rsp.data_ok));

endmodule

`default_nettype wire
